/* stm_core.f */
source/time_pkg.sv
source/stm_pkg.sv
source/stm_divider.sv
source/stm_timer.sv
source/stm_settings_regs.sv
source/stm_segment_select.sv
source/stm_core.sv
verif/stm_core_chk.sv
verif/stm_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the stm_core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module stm_core_tb \
  -f stm_core.f \
  -o stm_core_sim

./obj_dir/stm_core_sim

/* verif/stm_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_core_tb;

  localparam int HistDepth = time_pkg::IdxLatency;
  localparam int DoneTimeout = 200;
  localparam int RunCycles = 500;

  logic CLK;
  logic rst;
  time_pkg::sys_time_t sys_time;
  stm_pkg::host_wr_t wr;
  stm_pkg::idx_t idx;
  stm_pkg::seg_t segment;
  logic update_done;

  // model state as it should be right after the latest rising edge.
  stm_pkg::stm_setting_t mirror [stm_pkg::NumSegment];
  stm_pkg::stm_setting_t latched [stm_pkg::NumSegment];
  stm_pkg::seg_t seg_req_m;
  stm_pkg::seg_t seg_active;
  logic req_m;
  logic done_m;
  logic loading;
  int load_left;
  logic check_idx;
  time_pkg::sys_time_t hist [$];
  string test_name;

  stm_core uut (
    .CLK         (CLK),
    .rst         (rst),
    .sys_time    (sys_time),
    .wr          (wr),
    .idx         (idx),
    .segment     (segment),
    .update_done (update_done)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic compare(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s/%s expected %0d actual %0d", test_name, what, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // index = (coarse ticks / freq_div) mod (cycle + 1).
  function automatic stm_pkg::idx_t expected_idx(input time_pkg::sys_time_t t,
                                                 input stm_pkg::stm_setting_t s);
    logic [63:0] ticks;
    logic [63:0] samples;
    logic [63:0] period;
    logic [63:0] rem;
    ticks = {16'd0, t[time_pkg::TickMsb:time_pkg::TickLsb]};
    samples = ticks / {48'd0, s.freq_div};
    period = {51'd0, s.cycle} + 64'd1;
    rem = samples % period;
    return rem[12:0];
  endfunction

  task automatic reset_model();
    for (int i = 0; i < stm_pkg::NumSegment; i++) begin
      mirror[i] = '{cycle: 13'd0, freq_div: 16'd1};
      latched[i] = '{cycle: 13'd0, freq_div: 16'd1};
    end
    seg_req_m = '0;
    seg_active = '0;
    req_m = 1'b0;
    done_m = 1'b0;
    loading = 1'b0;
    load_left = 0;
    check_idx = 1'b0;
  endtask

  // advances the model over one rising edge, with wr as the DUT saw it.
  task automatic model_edge();
    if (done_m) begin
      seg_active = seg_req_m;
    end
    done_m = 1'b0;
    if (loading) begin
      load_left--;
      if (load_left == 0) begin
        done_m = 1'b1;
        loading = 1'b0;
        check_idx = 1'b1;
      end
    end else if (req_m) begin
      for (int i = 0; i < stm_pkg::NumSegment; i++) begin
        latched[i] = mirror[i];
      end
      loading = 1'b1;
      load_left = time_pkg::LoadLatency;
      check_idx = 1'b0; // the pipeline still holds samples with the old settings.
    end
    req_m = wr.en && (wr.addr == stm_pkg::AddrCommit);
    if (wr.en) begin
      case (wr.addr)
        stm_pkg::AddrCycle0: mirror[0].cycle = wr.data[12:0];
        stm_pkg::AddrFreqDiv0: mirror[0].freq_div = wr.data;
        stm_pkg::AddrCycle1: mirror[1].cycle = wr.data[12:0];
        stm_pkg::AddrFreqDiv1: mirror[1].freq_div = wr.data;
        stm_pkg::AddrSegReq: seg_req_m = wr.data[0];
        default: ;
      endcase
    end
  endtask

  task automatic tick(input stm_pkg::host_wr_t next_wr);
    @(negedge CLK);
    model_edge();
    compare("update_done", 64'(done_m), 64'(update_done));
    compare("segment", 64'(seg_active), 64'(segment));
    if (check_idx && hist.size() == HistDepth) begin
      compare("idx", 64'(expected_idx(hist[0], latched[seg_active])), 64'(idx));
    end
    wr = next_wr;
    sys_time = sys_time + time_pkg::sys_time_t'($urandom_range(20'hfffff, 0));
    hist.push_back(sys_time);
    if (hist.size() > HistDepth) begin
      hist.delete(0);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) tick('0);
  endtask

  task automatic host_write(input stm_pkg::reg_addr_t addr, input logic [15:0] data);
    stm_pkg::host_wr_t w;
    w.en = 1'b1;
    w.addr = addr;
    w.data = data;
    tick(w);
  endtask

  task automatic write_setting(input int seg, input stm_pkg::cycle_t cycle,
                               input stm_pkg::freq_div_t fd);
    host_write(seg == 0 ? stm_pkg::AddrCycle0 : stm_pkg::AddrCycle1, {3'd0, cycle});
    host_write(seg == 0 ? stm_pkg::AddrFreqDiv0 : stm_pkg::AddrFreqDiv1, fd);
  endtask

  task automatic write_random_settings();
    for (int s = 0; s < stm_pkg::NumSegment; s++) begin
      write_setting(s, 13'($urandom_range(8191, 0)), 16'($urandom_range(65535, 1)));
    end
  endtask

  task automatic wait_done(output int cycles);
    int n;
    for (n = 1; n <= DoneTimeout; n++) begin
      tick('0);
      if (update_done) break;
    end
    if (n > DoneTimeout) begin
      $display("timeout: update_done did not arrive within %0d cycles", DoneTimeout);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
    cycles = n;
  endtask

  // one cycle to update_req, LoadLatency in the timer, one more to see the pulse.
  task automatic commit_and_wait();
    int cycles;
    host_write(stm_pkg::AddrCommit, 16'h0);
    wait_done(cycles);
    compare("done_latency", 64'(time_pkg::LoadLatency + 2), 64'(cycles));
  endtask

  initial begin
    int cycles;
    stm_pkg::seg_t next_seg;
    void'($urandom(32'he2f6f94d));
    rst = 1'b1;
    wr = '0;
    sys_time = {5'd0, 24'($urandom), 32'($urandom)};
    test_name = "reset";
    reset_model();
    repeat (2) @(negedge CLK);
    rst = 1'b0;
    idle(150);

    test_name = "random_settings";
    for (int n = 0; n < 6; n++) begin
      write_random_settings();
      host_write(stm_pkg::AddrSegReq, 16'($urandom_range(1, 0)));
      commit_and_wait();
      idle(RunCycles);
    end

    test_name = "segment_switch";
    next_seg = ~seg_active;
    host_write(stm_pkg::AddrSegReq, {15'd0, next_seg});
    commit_and_wait();
    tick('0);
    compare("new_segment", 64'(next_seg), 64'(segment));
    idle(RunCycles);

    test_name = "commit_while_loading";
    write_random_settings();
    host_write(stm_pkg::AddrCommit, 16'h0);
    idle(20);
    write_random_settings(); // held in the registers until the next accepted commit.
    host_write(stm_pkg::AddrSegReq, {15'd0, ~seg_req_m});
    host_write(stm_pkg::AddrCommit, 16'h0);
    wait_done(cycles);
    idle(RunCycles);
    commit_and_wait();
    idle(RunCycles);

    test_name = "edge_settings";
    write_setting(0, 13'd8191, 16'd1);
    write_setting(1, 13'd0, 16'($urandom_range(65535, 1)));
    host_write(stm_pkg::AddrSegReq, 16'd0);
    commit_and_wait();
    idle(RunCycles);
    host_write(stm_pkg::AddrSegReq, 16'd1);
    commit_and_wait();
    for (int n = 0; n < RunCycles; n++) begin
      tick('0);
      compare("idx_cycle0", 64'd0, 64'(idx));
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/stm_core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_core_chk (
  input wire                 CLK,
  input wire                 rst,
  input wire                 update_req,
  input wire                 update_done,
  input wire stm_pkg::seg_t  segment
);

  logic busy;
  logic accept;
  logic [7:0] since_load; // zero until the first accepted request, then saturates.

  assign accept = update_req && (!busy || update_done);

  always_ff @(posedge CLK) begin
    if (rst) begin
      busy <= 1'b0;
      since_load <= '0;
    end else begin
      busy <= accept || (busy && !update_done);
      if (accept) begin
        since_load <= 8'd1;
      end else if (since_load != 8'd0 && since_load != 8'hff) begin
        since_load <= since_load + 8'd1;
      end
    end
  end

  done_single: assert property (@(posedge CLK) disable iff (rst)
    update_done |=> !update_done)
    else $error("update_done was high in two consecutive cycles");

  segment_on_done: assert property (@(posedge CLK) disable iff (rst)
    (segment != $past(segment)) |-> $past(update_done))
    else $error("segment changed without a preceding update_done");

  done_not_early: assert property (@(posedge CLK) disable iff (rst)
    update_done |-> (since_load > 8'(time_pkg::LoadLatency)))
    else $error("update_done came too soon after an accepted commit");

endmodule

bind stm_core stm_core_chk chk (
  .CLK         (CLK),
  .rst         (rst),
  .update_req  (update_req),
  .update_done (update_done),
  .segment     (segment)
);

`default_nettype wire

/* source/stm_core.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_core (
  input  wire                       CLK,
  input  wire                       rst,
  input  wire time_pkg::sys_time_t  sys_time,
  input  wire stm_pkg::host_wr_t    wr,
  output stm_pkg::idx_t             idx,
  output stm_pkg::seg_t             segment,
  output logic                      update_done
);

  stm_pkg::stm_setting_t setting [stm_pkg::NumSegment];
  stm_pkg::idx_t idx_all [stm_pkg::NumSegment];
  stm_pkg::seg_t seg_req;
  logic update_req;

  stm_settings_regs u_regs (
    .CLK        (CLK),
    .rst        (rst),
    .wr         (wr),
    .setting    (setting),
    .seg_req    (seg_req),
    .update_req (update_req)
  );

  stm_timer u_timer (
    .CLK         (CLK),
    .rst         (rst),
    .sys_time    (sys_time),
    .setting     (setting),
    .update_req  (update_req),
    .idx         (idx_all),
    .update_done (update_done)
  );

  stm_segment_select u_select (
    .CLK         (CLK),
    .rst         (rst),
    .seg_req     (seg_req),
    .update_done (update_done),
    .idx_all     (idx_all),
    .idx         (idx),
    .segment     (segment)
  );

endmodule

`default_nettype wire

/* source/stm_segment_select.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_segment_select (
  input  wire                 CLK,
  input  wire                 rst,
  input  wire stm_pkg::seg_t  seg_req,
  input  wire                 update_done,
  input  wire stm_pkg::idx_t  idx_all [stm_pkg::NumSegment],
  output stm_pkg::idx_t       idx,
  output stm_pkg::seg_t       segment
);

  // switching only with the done pulse keeps the segment and its settings in step.
  always_ff @(posedge CLK) begin
    if (rst) begin
      segment <= '0;
    end else if (update_done) begin
      segment <= seg_req;
    end
  end

  assign idx = idx_all[segment];

endmodule

`default_nettype wire

/* source/stm_settings_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_settings_regs (
  input  wire                     CLK,
  input  wire                     rst,
  input  wire stm_pkg::host_wr_t  wr,
  output stm_pkg::stm_setting_t   setting [stm_pkg::NumSegment],
  output stm_pkg::seg_t           seg_req,
  output logic                    update_req
);

  logic commit;

  assign commit = wr.en && (wr.addr == stm_pkg::AddrCommit);

  always_ff @(posedge CLK) begin
    if (rst) begin
      update_req <= 1'b0;
    end else begin
      update_req <= commit; // one cycle pulse per commit write.
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < stm_pkg::NumSegment; i++) begin
        setting[i] <= stm_pkg::DefaultSetting;
      end
      seg_req <= '0;
    end else if (wr.en) begin
      for (int i = 0; i < stm_pkg::NumSegment; i++) begin
        if (wr.addr == stm_pkg::CycleAddr[i]) begin
          setting[i].cycle <= wr.data[$bits(stm_pkg::cycle_t)-1:0];
        end
        if (wr.addr == stm_pkg::FreqDivAddr[i]) begin
          setting[i].freq_div <= wr.data;
        end
      end
      if (wr.addr == stm_pkg::AddrSegReq) begin
        seg_req <= wr.data[$bits(stm_pkg::seg_t)-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* source/stm_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_timer (
  input  wire                         CLK,
  input  wire                         rst,
  input  wire time_pkg::sys_time_t    sys_time,
  input  wire stm_pkg::stm_setting_t  setting [stm_pkg::NumSegment],
  input  wire                         update_req,
  output stm_pkg::idx_t               idx [stm_pkg::NumSegment],
  output logic                        update_done
);

  typedef enum logic {
    IDLE,
    LOAD
  } state_t;

  typedef logic [$clog2(time_pkg::LoadLatency)-1:0] load_cnt_t;

  state_t state;
  load_cnt_t cnt;
  logic load;

  assign load = (state == IDLE) && update_req; // a request during LOAD is dropped.

  for (genvar i = 0; i < stm_pkg::NumSegment; i++) begin : gen_seg
    stm_pkg::stm_setting_t latched;
    stm_pkg::freq_div_t period;
    time_pkg::tick_t sample_cnt;
    stm_pkg::freq_div_t idx_rem;
    stm_pkg::idx_t idx_q;

    assign period = stm_pkg::freq_div_t'(latched.cycle) + 1'b1; // at most 8192, fits 16 bits.

    always_ff @(posedge CLK) begin
      if (rst) begin
        latched <= stm_pkg::DefaultSetting;
      end else if (load) begin
        latched <= setting[i];
      end
    end

    stm_divider div_cnt (
      .CLK      (CLK),
      .dividend (sys_time[time_pkg::TickMsb:time_pkg::TickLsb]),
      .divisor  (latched.freq_div),
      .quotient (sample_cnt),
      .remainder()
    );

    stm_divider div_idx (
      .CLK      (CLK),
      .dividend (sample_cnt),
      .divisor  (period),
      .quotient (),
      .remainder(idx_rem)
    );

    always_ff @(posedge CLK) begin
      if (rst) begin
        idx_q <= '0;
      end else begin
        idx_q <= idx_rem[$bits(stm_pkg::idx_t)-1:0]; // remainder is below the period.
      end
    end

    assign idx[i] = idx_q;
  end

  // the done pulse waits until every sample in flight uses the new settings.
  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= IDLE;
      cnt <= '0;
      update_done <= 1'b0;
    end else begin
      update_done <= 1'b0;
      case (state)
        IDLE: begin
          cnt <= '0;
          if (load) begin
            state <= LOAD;
          end
        end
        LOAD: begin
          cnt <= cnt + 1'b1;
          if (cnt == load_cnt_t'(time_pkg::LoadLatency - 1)) begin
            update_done <= 1'b1;
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/stm_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_divider (
  input  wire                 CLK,
  input  wire time_pkg::tick_t dividend,
  input  wire stm_pkg::freq_div_t divisor,
  output time_pkg::tick_t     quotient,
  output stm_pkg::freq_div_t  remainder
);

  typedef struct packed {
    time_pkg::tick_t    shift; // dividend bits move out at the top, quotient bits in at the bottom.
    stm_pkg::freq_div_t rem;
    stm_pkg::freq_div_t den;
  } div_slot_t;

  div_slot_t slot [time_pkg::TickWidth+1];

  // one restoring step that yields one quotient bit.
  function automatic div_slot_t div_step(input div_slot_t s);
    div_slot_t o;
    logic [$bits(stm_pkg::freq_div_t):0] trial;
    trial = {s.rem, s.shift[time_pkg::TickWidth-1]};
    o = s;
    o.shift = {s.shift[time_pkg::TickWidth-2:0], 1'b0};
    if (trial >= {1'b0, s.den}) begin // a zero divisor always passes, so the quotient is all ones.
      trial = trial - {1'b0, s.den};
      o.shift[0] = 1'b1;
    end
    o.rem = trial[$bits(stm_pkg::freq_div_t)-1:0];
    return o;
  endfunction

  always_ff @(posedge CLK) begin
    slot[0] <= '{shift: dividend, rem: '0, den: divisor};
  end

  for (genvar i = 1; i <= time_pkg::TickWidth; i++) begin : gen_stage
    always_ff @(posedge CLK) begin
      slot[i] <= div_step(slot[i-1]);
    end
  end

  assign quotient = slot[time_pkg::TickWidth].shift;
  assign remainder = slot[time_pkg::TickWidth].rem;

endmodule

`default_nettype wire

/* source/stm_pkg.sv */
`default_nettype none

package stm_pkg;

  localparam int NumSegment = 2;

  typedef logic [$clog2(NumSegment)-1:0] seg_t;
  typedef logic [12:0] idx_t;
  typedef logic [12:0] cycle_t; // period is this value plus one.
  typedef logic [15:0] freq_div_t; // coarse ticks per sample.
  typedef logic [2:0] reg_addr_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    logic [15:0] data;
  } host_wr_t;

  typedef struct packed {
    cycle_t    cycle;
    freq_div_t freq_div;
  } stm_setting_t;

  localparam stm_setting_t DefaultSetting = '{cycle: '0, freq_div: 16'd1};

  localparam reg_addr_t AddrCycle0 = 3'd0;
  localparam reg_addr_t AddrFreqDiv0 = 3'd1;
  localparam reg_addr_t AddrCycle1 = 3'd2;
  localparam reg_addr_t AddrFreqDiv1 = 3'd3;
  localparam reg_addr_t AddrSegReq = 3'd4;
  localparam reg_addr_t AddrCommit = 3'd5; // data is ignored.

  localparam reg_addr_t CycleAddr [NumSegment] = '{AddrCycle0, AddrCycle1};
  localparam reg_addr_t FreqDivAddr [NumSegment] = '{AddrFreqDiv0, AddrFreqDiv1};

endpackage

`default_nettype wire

/* source/time_pkg.sv */
`default_nettype none

package time_pkg;

  localparam int SysTimeWidth = 61;
  localparam int TickLsb = 8;
  localparam int TickMsb = 55;
  localparam int TickWidth = TickMsb - TickLsb + 1;

  typedef logic [SysTimeWidth-1:0] sys_time_t;
  typedef logic [TickWidth-1:0] tick_t;

  localparam int DivLatency = TickWidth + 1; // input stage plus one stage per quotient bit.
  localparam int IdxLatency = 2 * DivLatency + 1; // two dividers and the index register.
  localparam int LoadLatency = IdxLatency + 2;

endpackage

`default_nettype wire
